// ==== verilog.f ====
+incdir+include
hw/cache_pkg.sv
hw/tag_axil_slave.sv
hw/tag_req_router.sv
hw/tag_way.sv
hw/tag_hit_resolver.sv
hw/tag_lookup_top.sv
tb/tb_clock_gen.sv
tb/tb_tag_lookup.sv

// ==== Bender.yml ====
package:
  name: tag_lookup

sources:
  - include_dirs:
      - include
    files:
      - hw/cache_pkg.sv
      - hw/tag_axil_slave.sv
      - hw/tag_req_router.sv
      - hw/tag_way.sv
      - hw/tag_hit_resolver.sv
      - hw/tag_lookup_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_tag_lookup.sv

// ==== tb/tb_tag_lookup.sv ====
// ----------------------------
// axi4-lite driver, tag model and directed and random commands for the tag subsystem
// concurrent assertions check every b and r beat
// ----------------------------
`timescale 1ns/1ps
`include "tag_regs.svh"

module tb_tag_lookup;

	localparam int CAPACITY = 128;
	localparam int BW_GRP   = $clog2(CAPACITY) - 2;
	localparam int BW_TAG   = cache_pkg::BW_BLOCK_ADDR - BW_GRP;
	localparam int NUM_GRP  = 2 ** BW_GRP;
	// about 330 commands of roughly 10 cycles each plus wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clock, resetn;
	logic [31:0] s_awaddr, s_wdata, s_araddr, s_rdata;
	logic        s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
	logic        s_arvalid, s_arready, s_rvalid, s_rready;
	logic [3:0]  s_wstrb;
	logic [1:0]  s_bresp, s_rresp;

	// expected beats for the next transfer
	logic [31:0] exp_rdata;
	logic [1:0]  exp_rresp, exp_bresp;
	string       test_name;

	// tag model
	logic [BW_TAG-1:0] ref_tag [cache_pkg::NUM_WAYS][NUM_GRP];
	logic              ref_valid [cache_pkg::NUM_WAYS][NUM_GRP];
	logic [31:0]       last_cmd, last_result;
	integer            seed;
	int                cycles;

	tb_clock_gen u_clk (.clock_o(clock), .resetn_o(resetn));

	tag_lookup_top #(.CACHE_BLOCK_CAPACITY(CAPACITY)) dut (
		.clock_i(clock), .resetn_i(resetn),
		.s_awaddr_i(s_awaddr), .s_awvalid_i(s_awvalid), .s_awready_o(s_awready),
		.s_wdata_i(s_wdata), .s_wstrb_i(s_wstrb), .s_wvalid_i(s_wvalid), .s_wready_o(s_wready),
		.s_bresp_o(s_bresp), .s_bvalid_o(s_bvalid), .s_bready_i(s_bready),
		.s_araddr_i(s_araddr), .s_arvalid_i(s_arvalid), .s_arready_o(s_arready),
		.s_rdata_o(s_rdata), .s_rresp_o(s_rresp), .s_rvalid_o(s_rvalid), .s_rready_i(s_rready)
	);

	task automatic stop_with_failure(input string why);
		$display("%0s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// checks
	// ----------------------------
	chk_rdata: assert property (@(posedge clock) disable iff (!resetn)
		s_rvalid && s_rready |-> s_rdata == exp_rdata)
		else stop_with_failure($sformatf("ERR %0s: rdata expected 0x%08h actual 0x%08h",
			test_name, exp_rdata, s_rdata));
	chk_rresp: assert property (@(posedge clock) disable iff (!resetn)
		s_rvalid && s_rready |-> s_rresp == exp_rresp)
		else stop_with_failure($sformatf("ERR %0s: rresp expected %0d actual %0d",
			test_name, exp_rresp, s_rresp));
	chk_bresp: assert property (@(posedge clock) disable iff (!resetn)
		s_bvalid && s_bready |-> s_bresp == exp_bresp)
		else stop_with_failure($sformatf("ERR %0s: bresp expected %0d actual %0d",
			test_name, exp_bresp, s_bresp));
	chk_bhold: assert property (@(posedge clock) disable iff (!resetn)
		s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
		else stop_with_failure({test_name, ": write response changed while bready was low"});
	chk_wblock: assert property (@(posedge clock) disable iff (!resetn)
		s_bvalid |-> !s_awready && !s_wready)
		else stop_with_failure({test_name, ": write channels ready while a B beat was pending"});
	chk_rblock: assert property (@(posedge clock) disable iff (!resetn)
		s_rvalid |-> !s_arready)
		else stop_with_failure({test_name, ": AR ready while an R beat was pending"});

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			stop_with_failure("timeout: the tests did not finish within the cycle limit");
	end

	// axi4-lite driver tasks start and end 1 ns after an edge
	// ----------------------------
	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] resp, input int hold);
		exp_bresp = resp;
		s_awaddr  = addr;
		s_wdata   = data;
		s_wstrb   = strb;
		s_awvalid = 1'b1;
		s_wvalid  = 1'b1;
		s_bready  = (hold == 0);
		while (!(s_awready && s_wready)) begin
			@(posedge clock);
			#1;
		end
		@(posedge clock);
		#1;
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
		repeat (hold) begin              // b back-pressure
			@(posedge clock);
			#1;
		end
		s_bready = 1'b1;
		while (!s_bvalid) begin
			@(posedge clock);
			#1;
		end
		@(posedge clock);
		#1;
		s_bready = 1'b0;
	endtask

	task automatic axil_read(input logic [31:0] addr, input logic [31:0] data,
		input logic [1:0] resp);
		exp_rdata = data;
		exp_rresp = resp;
		s_araddr  = addr;
		s_arvalid = 1'b1;
		s_rready  = 1'b1;
		while (!s_arready) begin
			@(posedge clock);
			#1;
		end
		@(posedge clock);
		#1;
		s_arvalid = 1'b0;
		while (!s_rvalid) begin
			@(posedge clock);
			#1;
		end
		@(posedge clock);
		#1;
		s_rready = 1'b0;
	endtask

	// reference model
	// ----------------------------
	function automatic logic [15:0] make_addr(input logic [31:0] tg, input logic [31:0] grp,
		input logic [31:0] off);
		return {tg[BW_TAG-1:0], grp[BW_GRP-1:0], off[1:0]};
	endfunction

	function automatic logic [31:0] apply_model(input logic [1:0] op, input logic [1:0] way,
		input logic [15:0] addr);
		logic [BW_GRP-1:0] grp;
		logic [BW_TAG-1:0] tg;
		logic [31:0]       res;
		grp = addr[cache_pkg::BW_BLOCK +: BW_GRP];
		tg  = addr[15 -: BW_TAG];
		res = '0;
		case (op)
			cache_pkg::LOOKUP: begin
				for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
					if (ref_valid[w][grp] && ref_tag[w][grp] == tg) begin
						res[`RES_HIT_BIT] = 1'b1;
						res[`RES_WAY_MSB:`RES_WAY_LSB] = w[1:0];
						res[`RES_BADDR_MSB:`RES_BADDR_LSB] = addr[15:2];
					end
				end
			end
			cache_pkg::FILL: begin
				ref_tag[way][grp]   = tg;
				ref_valid[way][grp] = 1'b1;
			end
			cache_pkg::INVALIDATE: ref_valid[way][grp] = 1'b0;
			default: begin                   // probe
				res[`RES_WAY_MSB:`RES_WAY_LSB] = way;
				if (ref_valid[way][grp]) begin
					res[`RES_HIT_BIT] = 1'b1;
					res[`RES_BADDR_MSB:`RES_BADDR_LSB] = {ref_tag[way][grp], grp};
				end
			end
		endcase
		return res;
	endfunction

	// a tag already held in another way of the group is refilled in place
	function automatic logic [1:0] pick_fill_way(input logic [1:0] way, input logic [15:0] addr);
		logic [BW_GRP-1:0] grp;
		logic [1:0]        sel;
		grp = addr[cache_pkg::BW_BLOCK +: BW_GRP];
		sel = way;
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			if (ref_valid[w][grp] && ref_tag[w][grp] == addr[15 -: BW_TAG]) sel = w[1:0];
		end
		return sel;
	endfunction

	task automatic send_cmd(input logic [1:0] op, input logic [1:0] way,
		input logic [15:0] addr, input int hold);
		logic [31:0] word;
		word = '0;
		word[`CMD_OP_MSB:`CMD_OP_LSB]     = op;
		word[`CMD_WAY_MSB:`CMD_WAY_LSB]   = way;
		word[`CMD_ADDR_MSB:`CMD_ADDR_LSB] = addr;
		axil_write(`REG_CMD, word, 4'hf, cache_pkg::RESP_OKAY, hold);
		last_cmd    = word;
		last_result = apply_model(op, way, addr);
	endtask

	task automatic cmd_and_check(input logic [1:0] op, input logic [1:0] way,
		input logic [15:0] addr);
		send_cmd(op, way, addr, 0);
		axil_read(`REG_RESULT, last_result, cache_pkg::RESP_OKAY);
	endtask

	// stimulus
	// ----------------------------
	initial begin
		logic [15:0] a, b, c, d;
		logic [31:0] r;
		logic [1:0]  op, way;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		exp_rdata = '0;
		exp_rresp = '0;
		exp_bresp = '0;
		last_cmd = '0;
		last_result = '0;
		cycles = 0;
		seed = 19442;
		test_name = "reset";
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			for (int g = 0; g < NUM_GRP; g++) begin
				ref_tag[w][g]   = '0;
				ref_valid[w][g] = 1'b0;
			end
		end
		wait (resetn);
		@(posedge clock);
		#1;

		a = make_addr(9'h1a5, 5'h0c, 1);
		b = make_addr(9'h0f3, 5'h0c, 3);
		c = make_addr(9'h111, 5'h0c, 0);
		d = make_addr(9'h07e, 5'h0c, 2);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, a);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, 16'hffff);
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) cmd_and_check(cache_pkg::PROBE, w[1:0], a);

		test_name = "fill_hit";
		cmd_and_check(cache_pkg::FILL, 2'd2, a);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, a);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, b);      // same group but other tag

		test_name = "invalidate";
		cmd_and_check(cache_pkg::FILL, 2'd0, b);
		cmd_and_check(cache_pkg::FILL, 2'd3, c);
		cmd_and_check(cache_pkg::INVALIDATE, 2'd2, a);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, a);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, b);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, c);

		test_name = "probe";
		cmd_and_check(cache_pkg::FILL, 2'd2, a);
		cmd_and_check(cache_pkg::PROBE, 2'd2, a);
		cmd_and_check(cache_pkg::FILL, 2'd2, d);        // replace slot
		cmd_and_check(cache_pkg::PROBE, 2'd2, a);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, a);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, d);

		// few tags and groups so hits are common
		test_name = "random";
		for (int i = 0; i < 300; i++) begin
			r   = $random(seed);
			op  = r[1:0];
			way = r[3:2];
			a   = make_addr(r[6:4], r[10:8], r[12:11]);
			if (op == cache_pkg::FILL) way = pick_fill_way(way, a);
			cmd_and_check(op, way, a);
			if (i % 8 == 0) axil_read(`REG_CMD, last_cmd, cache_pkg::RESP_OKAY);
		end

		test_name = "protocol";
		axil_write(`REG_RESULT, 32'h4000_1234, 4'hf, cache_pkg::RESP_SLVERR, 0);
		axil_write(32'h0000_0008, 32'h4000_0040, 4'hf, cache_pkg::RESP_SLVERR, 0);
		axil_write(`REG_CMD, 32'h4000_0ff0, 4'h3, cache_pkg::RESP_SLVERR, 0);
		axil_read(`REG_RESULT, last_result, cache_pkg::RESP_OKAY);
		axil_read(`REG_CMD, last_cmd, cache_pkg::RESP_OKAY);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, 16'h0ff0);
		axil_read(32'h0000_000c, 32'h0, cache_pkg::RESP_SLVERR);
		send_cmd(cache_pkg::FILL, pick_fill_way(2'd1, 16'h0ff0), 16'h0ff0, 6);
		cmd_and_check(cache_pkg::LOOKUP, 2'd0, 16'h0ff0);

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== tb/tb_clock_gen.sv ====
// ----------------------------
// testbench clock of 8 ns period and an active-low reset held for 5 cycles
// ----------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 5
)(
	output logic clock_o,
	output logic resetn_o
);

	initial begin
		clock_o = 1'b0;
		forever #(PERIOD_NS / 2) clock_o = ~clock_o;
	end

	initial begin
		resetn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_o);
		#1 resetn_o = 1'b1;              // released off the edge, like the stimulus
	end

endmodule

// ==== hw/tag_lookup_top.sv ====
// ----------------------------
// tag subsystem top: axi4-lite slave, router, four ways and hit resolver
// ----------------------------
`timescale 1ns/1ps

module tag_lookup_top #(
	parameter  int CACHE_BLOCK_CAPACITY = 128,
	localparam int BW_GRP = $clog2(CACHE_BLOCK_CAPACITY) - 2,
	localparam int BW_TAG = cache_pkg::BW_BLOCK_ADDR - BW_GRP
)(
	input  logic        clock_i,
	input  logic        resetn_i,
	input  logic [31:0] s_awaddr_i,
	input  logic        s_awvalid_i,
	output logic        s_awready_o,
	input  logic [31:0] s_wdata_i,
	input  logic [3:0]  s_wstrb_i,
	input  logic        s_wvalid_i,
	output logic        s_wready_o,
	output logic [1:0]  s_bresp_o,
	output logic        s_bvalid_o,
	input  logic        s_bready_i,
	input  logic [31:0] s_araddr_i,
	input  logic        s_arvalid_i,
	output logic        s_arready_o,
	output logic [31:0] s_rdata_o,
	output logic [1:0]  s_rresp_o,
	output logic        s_rvalid_o,
	input  logic        s_rready_i
);

	logic                                       req_valid;
	cache_pkg::tag_req_t                        req;
	cache_pkg::tag_resp_t                       resp;
	logic [BW_GRP-1:0]                          group;
	logic [BW_TAG-1:0]                          tag;
	logic [cache_pkg::NUM_WAYS-1:0]             fill_en, remove_en, match, valid;
	logic [cache_pkg::NUM_WAYS-1:0][BW_TAG-1:0] way_tag;

	tag_axil_slave u_slave (
		.clock_i, .resetn_i,
		.s_awaddr_i, .s_awvalid_i, .s_awready_o,
		.s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
		.s_bresp_o, .s_bvalid_o, .s_bready_i,
		.s_araddr_i, .s_arvalid_i, .s_arready_o,
		.s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
		.req_valid_o(req_valid), .req_o(req), .resp_i(resp)
	);

	tag_req_router #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) u_router (
		.req_valid_i(req_valid), .req_i(req),
		.group_o(group), .tag_o(tag),
		.fill_en_o(fill_en), .remove_en_o(remove_en)
	);

	// one identical block per way
	for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
		tag_way #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) u_way (
			.clock_i, .resetn_i,
			.group_i(group), .tag_i(tag),
			.fill_en_i(fill_en[w]), .remove_en_i(remove_en[w]),
			.match_o(match[w]), .valid_o(valid[w]), .tag_o(way_tag[w])
		);
	end

	tag_hit_resolver #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) u_resolver (
		.clock_i, .resetn_i,
		.req_valid_i(req_valid), .req_i(req),
		.match_i(match), .valid_i(valid), .way_tag_i(way_tag),
		.resp_o(resp)
	);

endmodule

// ==== hw/tag_hit_resolver.sv ====
// ----------------------------
// merges the way outputs into the registered response
// ----------------------------
`timescale 1ns/1ps

module tag_hit_resolver #(
	parameter  int CACHE_BLOCK_CAPACITY = 128,
	localparam int BW_GRP = $clog2(CACHE_BLOCK_CAPACITY) - 2,
	localparam int BW_TAG = cache_pkg::BW_BLOCK_ADDR - BW_GRP
)(
	input  logic                                       clock_i,
	input  logic                                       resetn_i,
	input  logic                                       req_valid_i,
	input  cache_pkg::tag_req_t                        req_i,
	input  logic [cache_pkg::NUM_WAYS-1:0]             match_i,
	input  logic [cache_pkg::NUM_WAYS-1:0]             valid_i,
	input  logic [cache_pkg::NUM_WAYS-1:0][BW_TAG-1:0] way_tag_i,
	output cache_pkg::tag_resp_t                       resp_o
);

	logic [BW_GRP-1:0]           group;
	logic [cache_pkg::BW_WAY-1:0] hit_way;
	cache_pkg::tag_resp_t        resp_d;

	assign group = req_i.addr[cache_pkg::BW_BLOCK +: BW_GRP];

	always_comb begin
		hit_way = '0;
		for (int i = 0; i < cache_pkg::NUM_WAYS; i++) begin
			if (match_i[i]) hit_way = cache_pkg::BW_WAY'(i);
		end
	end

	always_comb begin
		resp_d = '0;                  // fill / invalidate report nothing
		case (req_i.op)
			cache_pkg::LOOKUP: begin
				resp_d.hit = |match_i;
				resp_d.way = hit_way;
				if (|match_i) resp_d.block_addr = req_i.addr[cache_pkg::BW_WORD_ADDR-1:cache_pkg::BW_BLOCK];
			end
			cache_pkg::PROBE: begin
				resp_d.hit = valid_i[req_i.way];
				resp_d.way = req_i.way;
				// empty slot reads as zero address, like a lookup miss
				if (valid_i[req_i.way]) resp_d.block_addr = {way_tag_i[req_i.way], group};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) resp_o <= '0;
		else if (req_valid_i) resp_o <= resp_d;
	end

	// fills never place one tag in two ways of a group
	a_single_match: assert property (@(posedge clock_i) disable iff (!resetn_i)
		req_valid_i && (req_i.op == cache_pkg::LOOKUP) |-> $onehot0(match_i));

endmodule

// ==== hw/tag_way.sv ====
// ----------------------------
// one way of the tag memory: tag array, valid bits, match and probe read
// ----------------------------
`timescale 1ns/1ps

module tag_way #(
	parameter  int CACHE_BLOCK_CAPACITY = 128,
	localparam int BW_GRP = $clog2(CACHE_BLOCK_CAPACITY) - 2,
	localparam int BW_TAG = cache_pkg::BW_BLOCK_ADDR - BW_GRP
)(
	input  logic              clock_i,
	input  logic              resetn_i,
	input  logic [BW_GRP-1:0] group_i,
	input  logic [BW_TAG-1:0] tag_i,
	input  logic              fill_en_i,    // write tag, set valid
	input  logic              remove_en_i,  // clear valid
	output logic              match_o,
	output logic              valid_o,
	output logic [BW_TAG-1:0] tag_o
);

	localparam int NUM_GRP = 2 ** BW_GRP;

	logic [BW_TAG-1:0]  tag_mem [NUM_GRP];
	logic [NUM_GRP-1:0] valid_q;

	// storage
	// ----------------------------
	always_ff @(posedge clock_i) begin
		if (fill_en_i) tag_mem[group_i] <= tag_i;
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (fill_en_i) begin
			valid_q[group_i] <= 1'b1;
		end else if (remove_en_i) begin
			valid_q[group_i] <= 1'b0;
		end
	end

	// lookup and probe read
	// ----------------------------
	assign valid_o = valid_q[group_i];
	assign tag_o   = tag_mem[group_i];
	assign match_o = valid_o && (tag_o == tag_i);   // stale tags ignored

endmodule

// ==== hw/tag_req_router.sv ====
// ----------------------------
// splits a request into group, tag and per-way fill/remove enables
// ----------------------------
`timescale 1ns/1ps

module tag_req_router #(
	parameter  int CACHE_BLOCK_CAPACITY = 128,
	localparam int BW_GRP = $clog2(CACHE_BLOCK_CAPACITY) - 2,
	localparam int BW_TAG = cache_pkg::BW_BLOCK_ADDR - BW_GRP
)(
	input  logic                          req_valid_i,
	input  cache_pkg::tag_req_t           req_i,
	output logic [BW_GRP-1:0]             group_o,
	output logic [BW_TAG-1:0]             tag_o,
	output logic [cache_pkg::NUM_WAYS-1:0] fill_en_o,
	output logic [cache_pkg::NUM_WAYS-1:0] remove_en_o
);

	logic [cache_pkg::NUM_WAYS-1:0] way_sel;    // one-hot of req way
	logic                           do_fill, do_remove;

	// address slicing
	// ----------------------------
	// [ tag | group | word offset ]
	assign group_o = req_i.addr[cache_pkg::BW_BLOCK +: BW_GRP];
	assign tag_o   = req_i.addr[cache_pkg::BW_WORD_ADDR-1 -: BW_TAG];

	// enable decode
	// ----------------------------
	always_comb begin
		way_sel = '0;
		way_sel[req_i.way] = 1'b1;
	end

	assign do_fill   = req_valid_i && (req_i.op == cache_pkg::FILL);
	assign do_remove = req_valid_i && (req_i.op == cache_pkg::INVALIDATE);

	assign fill_en_o   = do_fill ? way_sel : '0;
	assign remove_en_o = do_remove ? way_sel : '0;

	// at most one way is written per request, never filled and removed together
	always_comb begin
		a_one_write: assert final ($onehot0(fill_en_o | remove_en_o)
			&& !(|fill_en_o && |remove_en_o));
	end

endmodule

// ==== hw/tag_axil_slave.sv ====
// ----------------------------
// axi4-lite slave front end: cmd writes become one-cycle requests, result reads
// ----------------------------
`timescale 1ns/1ps
`include "tag_regs.svh"

module tag_axil_slave (
	input  logic                 clock_i,
	input  logic                 resetn_i,
	input  logic [31:0]          s_awaddr_i,
	input  logic                 s_awvalid_i,
	output logic                 s_awready_o,
	input  logic [31:0]          s_wdata_i,
	input  logic [3:0]           s_wstrb_i,
	input  logic                 s_wvalid_i,
	output logic                 s_wready_o,
	output logic [1:0]           s_bresp_o,
	output logic                 s_bvalid_o,
	input  logic                 s_bready_i,
	input  logic [31:0]          s_araddr_i,
	input  logic                 s_arvalid_i,
	output logic                 s_arready_o,
	output logic [31:0]          s_rdata_o,
	output logic [1:0]           s_rresp_o,
	output logic                 s_rvalid_o,
	input  logic                 s_rready_i,
	output logic                 req_valid_o,
	output cache_pkg::tag_req_t  req_o,
	input  cache_pkg::tag_resp_t resp_i
);

	logic        aw_pend, w_pend;      // one channel arrived ahead of the other
	logic [31:0] awaddr_q, wdata_q;
	logic [3:0]  wstrb_q;
	logic        aw_fire, w_fire, wr_go, wr_ok;
	logic [31:0] wr_addr, wr_data;
	logic [3:0]  wr_strb;
	logic [31:0] cmd_q;                // last accepted command word
	logic [31:0] result_word;

	// write path
	// ----------------------------
	assign s_awready_o = !aw_pend && !s_bvalid_o;
	assign s_wready_o  = !w_pend && !s_bvalid_o;
	assign aw_fire = s_awvalid_i && s_awready_o;
	assign w_fire  = s_wvalid_i && s_wready_o;
	assign wr_go   = (aw_pend || aw_fire) && (w_pend || w_fire);
	assign wr_addr = aw_pend ? awaddr_q : s_awaddr_i;
	assign wr_data = w_pend ? wdata_q : s_wdata_i;
	assign wr_strb = w_pend ? wstrb_q : s_wstrb_i;
	assign wr_ok   = (wr_addr == `REG_CMD) && (wr_strb == 4'hf);

	always_ff @(posedge clock_i) begin
		if (aw_fire) awaddr_q <= s_awaddr_i;
		if (w_fire) begin
			wdata_q <= s_wdata_i;
			wstrb_q <= s_wstrb_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			aw_pend     <= 1'b0;
			w_pend      <= 1'b0;
			s_bvalid_o  <= 1'b0;
			s_bresp_o   <= cache_pkg::RESP_OKAY;
			req_valid_o <= 1'b0;
			cmd_q       <= '0;
		end else begin
			req_valid_o <= 1'b0;           // single-cycle pulse
			if (wr_go) begin
				aw_pend    <= 1'b0;
				w_pend     <= 1'b0;
				s_bvalid_o <= 1'b1;
				s_bresp_o  <= wr_ok ? cache_pkg::RESP_OKAY : cache_pkg::RESP_SLVERR;
				if (wr_ok) begin
					cmd_q       <= wr_data;
					req_valid_o <= 1'b1;
				end
			end else begin
				if (aw_fire) aw_pend <= 1'b1;
				if (w_fire) w_pend <= 1'b1;
			end
			if (s_bvalid_o && s_bready_i) s_bvalid_o <= 1'b0;
		end
	end

	// unpack the command word
	assign req_o.op   = cache_pkg::tag_op_e'(cmd_q[`CMD_OP_MSB:`CMD_OP_LSB]);
	assign req_o.way  = cmd_q[`CMD_WAY_MSB:`CMD_WAY_LSB];
	assign req_o.addr = cmd_q[`CMD_ADDR_MSB:`CMD_ADDR_LSB];

	// read path
	// ----------------------------
	always_comb begin
		result_word = '0;
		result_word[`RES_HIT_BIT]                 = resp_i.hit;
		result_word[`RES_WAY_MSB:`RES_WAY_LSB]     = resp_i.way;
		result_word[`RES_BADDR_MSB:`RES_BADDR_LSB] = resp_i.block_addr;
	end

	assign s_arready_o = !s_rvalid_o;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			s_rvalid_o <= 1'b0;
			s_rresp_o  <= cache_pkg::RESP_OKAY;
			s_rdata_o  <= '0;
		end else if (s_arvalid_i && s_arready_o) begin
			s_rvalid_o <= 1'b1;
			case (s_araddr_i)
				`REG_CMD: begin
					s_rdata_o <= cmd_q;
					s_rresp_o <= cache_pkg::RESP_OKAY;
				end
				`REG_RESULT: begin
					s_rdata_o <= result_word;
					s_rresp_o <= cache_pkg::RESP_OKAY;
				end
				default: begin
					s_rdata_o <= '0;         // unmapped
					s_rresp_o <= cache_pkg::RESP_SLVERR;
				end
			endcase
		end else if (s_rvalid_o && s_rready_i) begin
			s_rvalid_o <= 1'b0;
		end
	end

	// b beat holds until the master takes it
	a_b_hold: assert property (@(posedge clock_i) disable iff (!resetn_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

endmodule

// ==== hw/cache_pkg.sv ====
// ----------------------------
// shared widths, command encoding and request/response types for the tag subsystem
// ----------------------------

package cache_pkg;

	// fixed address geometry
	// ----------------------------
	localparam int BW_WORD_ADDR  = 16;                    // word address
	localparam int BW_BLOCK      = 2;                     // word offset inside a block
	localparam int BW_BLOCK_ADDR = BW_WORD_ADDR - BW_BLOCK;
	localparam int NUM_WAYS      = 4;                     // way index is 2 bits in cmd word
	localparam int BW_WAY        = $clog2(NUM_WAYS);

	// axi4-lite response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// command set
	// ----------------------------
	typedef enum logic [1:0] {
		LOOKUP     = 2'd0,  // hit/way query
		FILL       = 2'd1,  // write tag into given way
		INVALIDATE = 2'd2,  // clear valid bit of given way
		PROBE      = 2'd3   // reverse read of way/group
	} tag_op_e;

	// request from slave to router and resolver
	typedef struct packed {
		tag_op_e                 op;
		logic [BW_WAY-1:0]       way;
		logic [BW_WORD_ADDR-1:0] addr;
	} tag_req_t;

	// registered result back to slave
	typedef struct packed {
		logic                     hit;
		logic [BW_WAY-1:0]        way;
		logic [BW_BLOCK_ADDR-1:0] block_addr;
	} tag_resp_t;

endpackage

// ==== include/tag_regs.svh ====
// ----------------------------
// register map and cmd/result bit fields, shared by the slave and testbench
// ----------------------------
`ifndef TAG_REGS_SVH
`define TAG_REGS_SVH

`define REG_CMD        32'h0000_0000
`define REG_RESULT     32'h0000_0004

// cmd word fields
`define CMD_OP_MSB     31
`define CMD_OP_LSB     30
`define CMD_WAY_MSB    29
`define CMD_WAY_LSB    28
`define CMD_ADDR_MSB   15
`define CMD_ADDR_LSB   0

// result word fields, remaining bits read zero
`define RES_HIT_BIT    31
`define RES_WAY_MSB    29
`define RES_WAY_LSB    28
`define RES_BADDR_MSB  13
`define RES_BADDR_LSB  0

`endif
